// File: rtl/fp_noncomp.sv
// Per-lane min/max and sign-injection datapath with NaN handling and invalid flag
`timescale 1ns/1ps

module fp_noncomp import slice_pkg::*; (
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  input  operation_e  op_i,
  input  roundmode_e  rnd_mode_i,
  input  fp_format_e  fmt_i,
  output logic [31:0] result_o,
  output status_t     status_o
);

  logic [4:0]       sign_pos;   // MSB of the active format
  logic [4:0]       man_bits;
  logic [31:0]      mag_mask, man_mask, exp_mask, quiet_bit;
  logic [1:0][31:0] opnd;       // 0 is a, 1 is b
  logic [1:0][31:0] mag;
  logic [1:0]       sign, is_nan, is_snan, is_zero;
  logic             a_lt_b;

  // ------------------------------------------------------------------------
  // Format decode and classification
  // ------------------------------------------------------------------------
  always_comb begin : decode_format
    sign_pos  = 5'(fp_width(fmt_i) - 1);
    man_bits  = 5'(fp_width(fmt_i) - 1 - exp_bits(fmt_i));
    mag_mask  = (32'd1 << sign_pos) - 32'd1;
    man_mask  = (32'd1 << man_bits) - 32'd1;
    exp_mask  = mag_mask & ~man_mask;
    quiet_bit = 32'd1 << (man_bits - 5'd1);  // Top mantissa bit
  end

  assign opnd = {b_i, a_i};

  always_comb begin : classify
    for (int i = 0; i < 2; i++) begin
      sign[i]    = opnd[i][sign_pos];
      mag[i]     = opnd[i] & mag_mask;
      is_nan[i]  = ((opnd[i] & exp_mask) == exp_mask) && ((opnd[i] & man_mask) != '0);
      is_snan[i] = is_nan[i] && ((opnd[i] & quiet_bit) == '0);
      is_zero[i] = (mag[i] == '0);
    end
  end

  // Sign-magnitude ordering
  always_comb begin : compare
    if (is_zero[0] && is_zero[1]) begin
      a_lt_b = sign[0] & ~sign[1];  // -0 sits below +0
    end else if (sign[0] != sign[1]) begin
      a_lt_b = sign[0];
    end else if (sign[0]) begin
      a_lt_b = mag[0] > mag[1];     // Both negative
    end else begin
      a_lt_b = mag[0] < mag[1];
    end
  end

  // ------------------------------------------------------------------------
  // Result selection
  // ------------------------------------------------------------------------
  always_comb begin : compute
    logic new_sign;
    logic is_max;
    new_sign = sign[1];
    is_max   = (rnd_mode_i == RTZ);
    result_o = a_i;
    status_o = '0;
    if (op_i == MINMAX) begin
      if (&is_nan) begin
        result_o = canonical_nan(fmt_i);
      end else if (is_nan[0]) begin
        result_o = b_i;
      end else if (is_nan[1]) begin
        result_o = a_i;
      end else begin
        result_o = (is_max ^ a_lt_b) ? a_i : b_i;
      end
      status_o.nv = |is_snan;  // Quiet NaNs pass silently
    end else begin
      case (rnd_mode_i)
        RTZ:     new_sign = ~sign[1];          // SGNJN
        RDN:     new_sign = sign[0] ^ sign[1]; // SGNJX
        default: new_sign = sign[1];
      endcase
      result_o = mag[0] | (32'(new_sign) << sign_pos);
    end
  end

endmodule

// File: rtl/result_pack.sv
// Result packer with NaN-boxing of idle lanes and masked status collapse
`timescale 1ns/1ps

module result_pack import slice_pkg::*; (
  slice_ctrl_if.lane                   ctrl,
  input  logic    [NUM_LANES-1:0][31:0] lane_result_i,
  input  status_t [NUM_LANES-1:0]       lane_status_i,
  input  logic    [NUM_LANES-1:0]       lane_active_i,
  input  logic    [NUM_LANES-1:0]       lane_mask_i,
  output logic    [FLEN-1:0]            result_o,
  output status_t                       status_o
);

  localparam int unsigned NUM_HALVES = FLEN / fp_width(FP16);

  logic [NUM_LANES-1:0] lane_keep;
  fp_word_u             packed_word;

  // Scalar ops only ever keep lane 0
  always_comb begin : keep_lanes
    lane_keep = lane_active_i;
    for (int i = 1; i < int'(NUM_LANES); i++) begin
      lane_keep[i] = lane_active_i[i] & ctrl.out_vectorial;
    end
  end

  // ------------------------------------------------------------------------
  // Packing
  // ------------------------------------------------------------------------
  always_comb begin : pack
    packed_word = '1;  // Idle bits read as NaN-box
    case (ctrl.out_fmt)
      FP32: begin
        if (lane_keep[0]) packed_word.fp32 = lane_result_i[0];
      end
      FP16: begin
        for (int i = 0; i < int'(NUM_HALVES); i++) begin
          if (lane_keep[i]) packed_word.fp16[i] = lane_result_i[i][15:0];
        end
      end
      default: begin
        for (int i = 0; i < int'(NUM_LANES); i++) begin
          if (lane_keep[i]) packed_word.fp8[i] = lane_result_i[i][7:0];
        end
      end
    endcase
  end

  assign result_o = packed_word.fp32;

  always_comb begin : collapse_status
    status_o = '0;
    for (int i = 0; i < int'(NUM_LANES); i++) begin
      status_o |= lane_status_i[i] & {$bits(status_t){lane_mask_i[i]}};
    end
  end

endmodule

// File: rtl/simd_lane.sv
// SIMD lane that slices its operands, pipelines them and computes at the output
`timescale 1ns/1ps

module simd_lane import slice_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned LANE        = 0
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic [FLEN-1:0] operand_a_i,
  input  logic [FLEN-1:0] operand_b_i,
  input  fp_format_e      fmt_i,
  input  logic            vectorial_op_i,
  input  logic            mask_i,
  slice_ctrl_if.lane      ctrl,
  output logic [31:0]     result_o,
  output status_t         status_o,
  output logic            active_o,
  output logic            mask_o
);

  // Only the lower lanes have an FP16 half of their own
  localparam int unsigned HALF_IDX = (LANE < FLEN / fp_width(FP16)) ? LANE : 0;

  fp_word_u    word_a, word_b;
  logic [31:0] slice_a, slice_b;
  logic [31:0] pipe_a      [0:NumPipeRegs];
  logic [31:0] pipe_b      [0:NumPipeRegs];
  logic        pipe_active [0:NumPipeRegs];
  logic        pipe_mask   [0:NumPipeRegs];
  status_t     op_status;

  assign word_a = operand_a_i;
  assign word_b = operand_b_i;

  always_comb begin : slice_operands
    case (fmt_i)
      FP32: begin
        slice_a = word_a.fp32;
        slice_b = word_b.fp32;
      end
      FP16: begin
        slice_a = 32'(word_a.fp16[HALF_IDX]);
        slice_b = 32'(word_b.fp16[HALF_IDX]);
      end
      default: begin
        slice_a = 32'(word_a.fp8[LANE]);
        slice_b = 32'(word_b.fp8[LANE]);
      end
    endcase
  end

  // Lane must fit the format, upper lanes only join vector ops
  assign pipe_active[0] = (LANE < FLEN / fp_width(fmt_i)) && ((LANE == 0) || vectorial_op_i);
  assign pipe_a[0]      = slice_a;
  assign pipe_b[0]      = slice_b;
  assign pipe_mask[0]   = mask_i;

  // ------------------------------------------------------------------------
  // Input registers
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        pipe_active[i+1] <= 1'b0;
        pipe_mask[i+1]   <= 1'b0;
      end else if (ctrl.reg_enable[i]) begin
        pipe_active[i+1] <= pipe_active[i];
        pipe_mask[i+1]   <= pipe_mask[i];
      end
    end

    // Idle lanes keep their operands frozen
    always_ff @(posedge clk_i) begin
      if (ctrl.reg_enable[i] && pipe_active[i]) begin
        pipe_a[i+1] <= pipe_a[i];
        pipe_b[i+1] <= pipe_b[i];
      end
    end
  end

  fp_noncomp u_noncomp (
    .a_i        ( pipe_a[NumPipeRegs] ),
    .b_i        ( pipe_b[NumPipeRegs] ),
    .op_i       ( ctrl.out_op         ),
    .rnd_mode_i ( ctrl.out_rnd        ),
    .fmt_i      ( ctrl.out_fmt        ),
    .result_o   ( result_o            ),
    .status_o   ( op_status           )
  );

  assign active_o = pipe_active[NumPipeRegs];
  assign mask_o   = pipe_mask[NumPipeRegs];
  assign status_o = active_o ? op_status : '0;

endmodule

// File: rtl/simd_slice.sv
// Top of the non-computational SIMD slice with min/max and sign injection
`timescale 1ns/1ps

module simd_slice import slice_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [FLEN-1:0]      operand_a_i,
  input  logic [FLEN-1:0]      operand_b_i,
  input  roundmode_e           rnd_mode_i,
  input  operation_e           op_i,
  input  fp_format_e           fmt_i,
  input  logic                 vectorial_op_i,
  input  logic [NUM_LANES-1:0] simd_mask_i,
  input  logic [TagWidth-1:0]  tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  output logic [FLEN-1:0]      result_o,
  output status_t              status_o,
  output logic [TagWidth-1:0]  tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  logic    [NUM_LANES-1:0][31:0] lane_result;
  status_t [NUM_LANES-1:0]       lane_status;
  logic    [NUM_LANES-1:0]       lane_active;
  logic    [NUM_LANES-1:0]       lane_mask;

  slice_ctrl_if #(.NumPipeRegs(NumPipeRegs)) u_ctrl_if ();

  slice_pipe_ctrl #(
    .NumPipeRegs ( NumPipeRegs ),
    .TagWidth    ( TagWidth    )
  ) u_pipe_ctrl (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .tag_i          ( tag_i          ),
    .op_i           ( op_i           ),
    .rnd_mode_i     ( rnd_mode_i     ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .flush_i        ( flush_i        ),
    .tag_o          ( tag_o          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         ),
    .ctrl           ( u_ctrl_if      )
  );

  for (genvar i = 0; i < int'(NUM_LANES); i++) begin : gen_lane
    simd_lane #(
      .NumPipeRegs ( NumPipeRegs ),
      .LANE        ( i           )
    ) u_lane (
      .clk_i          ( clk_i          ),
      .arst_n_i       ( arst_n_i       ),
      .operand_a_i    ( operand_a_i    ),
      .operand_b_i    ( operand_b_i    ),
      .fmt_i          ( fmt_i          ),
      .vectorial_op_i ( vectorial_op_i ),
      .mask_i         ( simd_mask_i[i] ),
      .ctrl           ( u_ctrl_if      ),
      .result_o       ( lane_result[i] ),
      .status_o       ( lane_status[i] ),
      .active_o       ( lane_active[i] ),
      .mask_o         ( lane_mask[i]   )
    );
  end

  result_pack u_result_pack (
    .ctrl          ( u_ctrl_if   ),
    .lane_result_i ( lane_result ),
    .lane_status_i ( lane_status ),
    .lane_active_i ( lane_active ),
    .lane_mask_i   ( lane_mask   ),
    .result_o      ( result_o    ),
    .status_o      ( status_o    )
  );

endmodule

// File: rtl/slice_ctrl_if.sv
// Control bundle from the pipeline controller to the lanes and the result packer
`timescale 1ns/1ps

interface slice_ctrl_if import slice_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2
) ();

  logic [NumPipeRegs-1:0] reg_enable;  // One enable per register stage

  // Operation info of the item in the last stage
  operation_e out_op;
  roundmode_e out_rnd;
  fp_format_e out_fmt;
  logic       out_vectorial;

  modport ctrl (
    output reg_enable,
    output out_op,
    output out_rnd,
    output out_fmt,
    output out_vectorial
  );

  modport lane (
    input reg_enable,
    input out_op,
    input out_rnd,
    input out_fmt,
    input out_vectorial
  );

endinterface

// File: rtl/slice_pipe_ctrl.sv
// Valid/ready pipeline controller moving tag and operation info alongside the lanes
`timescale 1ns/1ps

module slice_pipe_ctrl import slice_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [TagWidth-1:0] tag_i,
  input  operation_e          op_i,
  input  roundmode_e          rnd_mode_i,
  input  fp_format_e          fmt_i,
  input  logic                vectorial_op_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  output logic [TagWidth-1:0] tag_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                busy_o,
  slice_ctrl_if.ctrl          ctrl
);

  // Index 0 is the input side, index NumPipeRegs the last stage
  logic                stage_valid [0:NumPipeRegs];
  logic                stage_ready [0:NumPipeRegs];
  logic [TagWidth-1:0] stage_tag   [0:NumPipeRegs];
  operation_e          stage_op    [0:NumPipeRegs];
  roundmode_e          stage_rnd   [0:NumPipeRegs];
  fp_format_e          stage_fmt   [0:NumPipeRegs];
  logic                stage_vec   [0:NumPipeRegs];

  assign stage_valid[0]           = in_valid_i;
  assign stage_tag[0]             = tag_i;
  assign stage_op[0]              = op_i;
  assign stage_rnd[0]             = rnd_mode_i;
  assign stage_fmt[0]             = fmt_i;
  assign stage_vec[0]             = vectorial_op_i;
  assign stage_ready[NumPipeRegs] = out_ready_i;

  // ------------------------------------------------------------------------
  // Register stages
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    // Stage i+1 accepts when empty or when its own content moves on
    assign stage_ready[i]     = stage_ready[i+1] | ~stage_valid[i+1];
    assign ctrl.reg_enable[i] = stage_valid[i] & stage_ready[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;  // Drop everything in flight
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (ctrl.reg_enable[i]) begin
        stage_tag[i+1] <= stage_tag[i];
        stage_op[i+1]  <= stage_op[i];
        stage_rnd[i+1] <= stage_rnd[i];
        stage_fmt[i+1] <= stage_fmt[i];
        stage_vec[i+1] <= stage_vec[i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------------------
  assign in_ready_o         = stage_ready[0];
  assign out_valid_o        = stage_valid[NumPipeRegs];
  assign tag_o              = stage_tag[NumPipeRegs];
  assign ctrl.out_op        = stage_op[NumPipeRegs];
  assign ctrl.out_rnd       = stage_rnd[NumPipeRegs];
  assign ctrl.out_fmt       = stage_fmt[NumPipeRegs];
  assign ctrl.out_vectorial = stage_vec[NumPipeRegs];

  always_comb begin : busy_flag
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o |= stage_valid[i];
    end
  end

endmodule

// File: rtl/slice_pkg.sv
// Slice package with formats, operation encodings, status flags and lane views
package slice_pkg;

  // ------------------------------------------------------------------------
  // Slice geometry
  // ------------------------------------------------------------------------
  localparam int unsigned FLEN      = 32;
  localparam int unsigned NUM_LANES = FLEN / 8;  // Narrowest format is 8 bits wide

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2   // E5M2
  } fp_format_e;

  typedef enum logic {
    MINMAX = 1'b0,
    SGNJ   = 1'b1
  } operation_e;

  // RISC-V rm field, doubles as variant select
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,  // MINMAX max, SGNJ negated
    RDN = 3'b010,  // SGNJ xor
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Same 32-bit word, read as one scalar or as SIMD lanes
  typedef union packed {
    logic [FLEN-1:0]                fp32;
    logic [NUM_LANES/2-1:0][15:0]   fp16;
    logic [NUM_LANES-1:0][7:0]      fp8;
  } fp_word_u;

  // ------------------------------------------------------------------------
  // Format properties
  // ------------------------------------------------------------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP32:    return 32;
      FP16:    return 16;
      default: return 8;
    endcase
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    if (fmt == FP32) return 8;
    return 5;  // FP16 and E5M2 share the exponent length
  endfunction

  function automatic logic [FLEN-1:0] canonical_nan(fp_format_e fmt);
    case (fmt)
      FP32:    return 32'h7fc0_0000;
      FP16:    return 32'h0000_7e00;
      default: return 32'h0000_007e;
    endcase
  endfunction

endpackage

// File: run_sim.sh
#!/bin/sh
# Compile and run the SIMD slice testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_simd_slice -f simd_slice.f -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: simd_slice.f
+incdir+testbench
rtl/slice_pkg.sv
rtl/slice_ctrl_if.sv
rtl/slice_pipe_ctrl.sv
rtl/fp_noncomp.sv
rtl/simd_lane.sv
rtl/result_pack.sv
rtl/simd_slice.sv
testbench/tb_simd_slice.sv

// File: testbench/tb_vectors.svh
// Stimulus and expected-value table for the SIMD slice testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  operation_e           op;
  roundmode_e           rnd;
  fp_format_e           fmt;
  logic                 vec;
  logic [NUM_LANES-1:0] mask;
  logic [FLEN-1:0]      a;
  logic [FLEN-1:0]      b;
  logic [FLEN-1:0]      res;
  status_t              st;
} vec_row_t;

localparam int NUM_VECS = 23;

// Columns: op, rnd, fmt, vectorial, mask, operand a, operand b, result, status
localparam vec_row_t VECTORS [NUM_VECS] = '{
  // Scalar sign injection, FP32 then FP16
  '{SGNJ,   RNE, FP32, 1'b0, 4'h1, 32'h3f80_0000, 32'hc000_0000, 32'hbf80_0000, 5'h00},
  '{SGNJ,   RTZ, FP32, 1'b0, 4'h1, 32'hbf80_0000, 32'hc000_0000, 32'h3f80_0000, 5'h00},
  '{SGNJ,   RDN, FP32, 1'b0, 4'h1, 32'hbf80_0000, 32'h4000_0000, 32'hbf80_0000, 5'h00},
  '{SGNJ,   RNE, FP16, 1'b0, 4'h1, 32'h1234_3c00, 32'h0000_c000, 32'hffff_bc00, 5'h00},
  '{SGNJ,   RTZ, FP16, 1'b0, 4'h1, 32'h0000_4500, 32'h0000_8000, 32'hffff_4500, 5'h00},
  '{SGNJ,   RDN, FP16, 1'b0, 4'h1, 32'hffff_c500, 32'h0000_4000, 32'hffff_c500, 5'h00},
  // FP32 min/max with NaN and signed zero rules
  '{MINMAX, RNE, FP32, 1'b0, 4'h1, 32'h7fc0_0000, 32'h3f80_0000, 32'h3f80_0000, 5'h00},
  '{MINMAX, RTZ, FP32, 1'b0, 4'h1, 32'h4000_0000, 32'h7fc0_0001, 32'h4000_0000, 5'h00},
  '{MINMAX, RNE, FP32, 1'b0, 4'h1, 32'h7fc0_0abc, 32'hffc1_2345, 32'h7fc0_0000, 5'h00},
  '{MINMAX, RNE, FP32, 1'b0, 4'h1, 32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 5'h00},
  '{MINMAX, RTZ, FP32, 1'b0, 4'h1, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 5'h00},
  '{MINMAX, RNE, FP32, 1'b0, 4'h1, 32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000, 5'h10},
  '{MINMAX, RNE, FP32, 1'b0, 4'h1, 32'hc000_0000, 32'hbf80_0000, 32'hc000_0000, 5'h00},
  // Scalar E5M2, upper bytes of a hold signaling NaNs that must stay silent
  '{MINMAX, RNE, FP8,  1'b0, 4'hf, 32'h7d7d_7d7e, 32'h0000_003c, 32'hffff_ff3c, 5'h00},
  '{MINMAX, RTZ, FP8,  1'b0, 4'h1, 32'h0000_007f, 32'h0000_007d, 32'hffff_ff7e, 5'h10},
  '{MINMAX, RNE, FP8,  1'b0, 4'h1, 32'h0000_0080, 32'h0000_0000, 32'hffff_ff80, 5'h00},
  '{MINMAX, RTZ, FP8,  1'b0, 4'h1, 32'h0000_0040, 32'h0000_007d, 32'hffff_ff40, 5'h10},
  // Vector rows, every lane with its own values
  '{MINMAX, RNE, FP8,  1'b1, 4'hf, 32'h40c0_7e00, 32'h3cbc_3c80, 32'h3cc0_3c80, 5'h00},
  '{SGNJ,   RDN, FP8,  1'b1, 4'hf, 32'h3cbc_40c0, 32'h8080_003c, 32'hbc3c_40c0, 5'h00},
  '{MINMAX, RTZ, FP16, 1'b1, 4'h3, 32'hc000_3c00, 32'hbc00_7e00, 32'hbc00_3c00, 5'h00},
  '{SGNJ,   RNE, FP16, 1'b1, 4'h3, 32'h4500_bc00, 32'h8000_4000, 32'hc500_3c00, 5'h00},
  // Signaling NaN in lane 2, with and without its mask bit
  '{MINMAX, RNE, FP8,  1'b1, 4'hf, 32'h007d_3c40, 32'h3c40_403c, 32'h0040_3c3c, 5'h10},
  '{MINMAX, RNE, FP8,  1'b1, 4'hb, 32'h007d_3c40, 32'h3c40_403c, 32'h0040_3c3c, 5'h00}
};

`endif

// File: testbench/tb_simd_slice.sv
// Testbench for the SIMD slice with table-driven stimulus and an in-order scoreboard
`timescale 1ns/1ps

module tb_simd_slice import slice_pkg::*; ();

  `include "tb_vectors.svh"

  localparam int NUM_PIPE     = 2;
  localparam int TAG_W        = 8;
  localparam int MAX_CYCLES   = 20 * NUM_VECS + 200;
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  logic                 clk_i;
  logic                 arst_n_i;
  logic [FLEN-1:0]      operand_a_i, operand_b_i;
  roundmode_e           rnd_mode_i;
  operation_e           op_i;
  fp_format_e           fmt_i;
  logic                 vectorial_op_i;
  logic [NUM_LANES-1:0] simd_mask_i;
  logic [TAG_W-1:0]     tag_i, tag_o;
  logic                 in_valid_i, in_ready_o, flush_i;
  logic [FLEN-1:0]      result_o;
  status_t              status_o;
  logic                 out_valid_o, out_ready_i, busy_o;

  integer seed          = 32'h4f53_d36d;
  int     cycle         = 0;
  int     error_count   = 0;
  int     ready_mode    = READY_HIGH;
  logic   check_latency = 1'b1;
  int     cur_idx       = 0;
  int     exp_idx [$];  // In-flight rows, oldest first
  int     exp_tag [$];
  int     exp_cyc [$];  // Cycle of the input handshake

  simd_slice #(
    .NumPipeRegs ( NUM_PIPE ),
    .TagWidth    ( TAG_W    )
  ) u_dut (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .operand_a_i    ( operand_a_i    ),
    .operand_b_i    ( operand_b_i    ),
    .rnd_mode_i     ( rnd_mode_i     ),
    .op_i           ( op_i           ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .simd_mask_i    ( simd_mask_i    ),
    .tag_i          ( tag_i          ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .flush_i        ( flush_i        ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .tag_o          ( tag_o          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         )
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Error reporting
  // --------------------------------------------------------------------------
  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    error_count++;
    $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, want);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic report_problem(input string msg);
    error_count++;
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at the first error");
  endtask

  // Cycle count and run limit
  always @(posedge clk_i) begin
    cycle++;
    if (cycle > MAX_CYCLES) begin
      report_problem($sformatf("Timeout, the run went past %0d cycles", MAX_CYCLES));
    end
  end

  // Output back-pressure, one random draw per cycle
  always begin : drive_ready
    int r;
    @(posedge clk_i);
    #0.5;
    r = $random(seed);
    case (ready_mode)
      READY_RANDOM: out_ready_i = r[0];
      READY_LOW:    out_ready_i = 1'b0;
      default:      out_ready_i = 1'b1;
    endcase
  end

  // --------------------------------------------------------------------------
  // Scoreboard, sampled mid-cycle
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin : scoreboard
    vec_row_t row;
    int       idx;
    int       tag;
    int       cyc;
    if (arst_n_i) begin
      if (out_valid_o && out_ready_i) begin
        assert (exp_idx.size() > 0)
          else report_problem($sformatf("Output with tag %0h came with nothing in flight",
                                        tag_o));
        idx = exp_idx.pop_front();
        tag = exp_tag.pop_front();
        cyc = exp_cyc.pop_front();
        row = VECTORS[idx];
        assert (tag_o == TAG_W'(tag))
          else report_mismatch($sformatf("row %0d tag", idx), 32'(tag_o), 32'(tag));
        assert (result_o == row.res)
          else report_mismatch($sformatf("row %0d result", idx), result_o, row.res);
        assert (status_o == row.st)
          else report_mismatch($sformatf("row %0d status", idx), 32'(status_o), 32'(row.st));
        assert (!check_latency || (cycle - cyc == NUM_PIPE))
          else report_mismatch($sformatf("row %0d latency", idx), cycle - cyc, NUM_PIPE);
      end
      if (flush_i) begin
        exp_idx.delete();  // Nothing in flight survives
        exp_tag.delete();
        exp_cyc.delete();
      end else if (in_valid_i && in_ready_o) begin
        exp_idx.push_back(cur_idx);
        exp_tag.push_back(int'(tag_i));
        exp_cyc.push_back(cycle);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Driver tasks
  // --------------------------------------------------------------------------
  task automatic load_row(input int idx, input logic [TAG_W-1:0] tag);
    cur_idx        = idx;
    op_i           = VECTORS[idx].op;
    rnd_mode_i     = VECTORS[idx].rnd;
    fmt_i          = VECTORS[idx].fmt;
    vectorial_op_i = VECTORS[idx].vec;
    simd_mask_i    = VECTORS[idx].mask;
    operand_a_i    = VECTORS[idx].a;
    operand_b_i    = VECTORS[idx].b;
    tag_i          = tag;
    in_valid_i     = 1'b1;
  endtask

  task automatic send_row(input int idx, input logic [TAG_W-1:0] tag);
    logic accepted;
    load_row(idx, tag);
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = in_ready_o;
      @(posedge clk_i);
      #0.5;
    end
  endtask

  task automatic drain();
    in_valid_i = 1'b0;
    do @(negedge clk_i); while (busy_o);
    @(posedge clk_i);
    #0.5;
  endtask

  // Mode changes land while the pipeline is empty
  task automatic set_ready_mode(input int mode);
    @(posedge clk_i);
    #1;
    ready_mode    = mode;
    check_latency = (mode == READY_HIGH);
    @(posedge clk_i);
    #0.5;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : run_tests
    arst_n_i       = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    rnd_mode_i     = RNE;
    op_i           = MINMAX;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = '0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b0;

    repeat (16) @(posedge clk_i);
    #0.5;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o) else report_problem("Outputs not idle after reset");
    @(posedge clk_i);
    #0.5;

    // Back to back with the output always ready
    for (int i = 0; i < NUM_VECS; i++) send_row(i, TAG_W'(i));
    drain();

    // Random back-pressure
    set_ready_mode(READY_RANDOM);
    for (int i = 0; i < NUM_VECS; i++) send_row(i, TAG_W'(8'h40 + i));
    drain();

    // Fill both stages against a stalled output, then flush
    set_ready_mode(READY_LOW);
    send_row(0, 8'h80);
    send_row(1, 8'h81);
    load_row(2, 8'h82);
    repeat (2) begin
      @(negedge clk_i);
      assert (!in_ready_o) else report_problem("Input accepted while the pipeline was full");
      @(posedge clk_i);
      #0.5;
    end
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(posedge clk_i);
    #0.5;
    flush_i = 1'b0;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o) else report_problem("Pipeline not empty after flush");

    // Flushed tags must never show up
    set_ready_mode(READY_HIGH);
    for (int i = 0; i < 4; i++) send_row(i, TAG_W'(8'hc0 + i));
    drain();

    assert (exp_idx.size() == 0) else report_problem("Rows left over after the pipeline drained");
    if (error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "Errors were found");
    end
  end

endmodule
